// ==== build.f ====
+incdir+src
+incdir+tb
src/ReplayQueuePkg.sv
src/ReplayQueuePointer.sv
src/ReplayQueueRam.sv
src/ReplayScheduler.sv
src/ReplayFlushFilter.sv
src/ReplayQueue.sv
tb/ReplayQueueTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the replay queue testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
    -f build.f --top-module ReplayQueueTb -Mdir obj_dir -o simReplayQueue \
    && ./obj_dir/simReplayQueue | tee sim.log \
    && ! grep -q "TESTS FAILED" sim.log \
    && echo "Replay queue simulation passed" \
    || { echo "Replay queue simulation failed"; exit 1; }

// ==== src/ReplayFlushFilter.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Replay flush filter
// Captures a recovery range, masks replayed lanes inside it and
// releases the MSHRs owned by flushed loads
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "replayQueue_macros.svh"

module ReplayFlushFilter
    import ReplayQueuePkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  RecoveryReq            recovery,
    input  RqCount                count,
    input  ReplayEntry            replayEntry,
    input  logic                  replay,
    output ReplayEntry            replayOut,
    output logic [`MSHR_NUM-1:0]  mshrRelease
);

    // Entries that were queued when the recovery hit
    RqCount       flushCount;
    ActiveListPtr rangeHead;
    ActiveListPtr rangeTail;
    logic         flushActive;

    // Circular range check, both ends inclusive
    function automatic logic inRange(ActiveListPtr ptr, ActiveListPtr head,
                                     ActiveListPtr tail);
        if (head <= tail) begin
            return (ptr >= head) && (ptr <= tail);
        end
        return (ptr >= head) || (ptr <= tail);
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            flushCount <= '0;
        end else if (recovery.strobe) begin
            flushCount <= count;
        end else if (flushActive && replay) begin
            flushCount <= flushCount - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (recovery.strobe) begin
            rangeHead <= recovery.flushHeadPtr;
            rangeTail <= recovery.flushTailPtr;
        end
    end

    assign flushActive = (flushCount != '0);

    always_comb begin
        replayOut   = replayEntry;
        mshrRelease = '0;
        for (int i = 0; i < `RQ_INT_WIDTH; i++) begin
            if (flushActive &&
                inRange(replayEntry.intLanes[i].activeListPtr, rangeHead, rangeTail)) begin
                replayOut.intLanes[i].valid = 1'b0;
            end
        end
        for (int i = 0; i < `RQ_MEM_WIDTH; i++) begin
            if (flushActive &&
                inRange(replayEntry.memLanes[i].activeListPtr, rangeHead, rangeTail)) begin
                replayOut.memLanes[i].valid = 1'b0;
                // A flushed miss owner frees its MSHR
                if (replayEntry.memLanes[i].valid &&
                    replayEntry.memLanes[i].opType == MEM_OP_LOAD &&
                    replayEntry.memLanes[i].hasMshr) begin
                    mshrRelease[replayEntry.memLanes[i].mshrId] = 1'b1;
                end
            end
        end
    end

endmodule

// ==== src/ReplayQueue.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Replay queue top
// Records issued op groups and replays them in order with their
// original spacing, holding for MSHR fills and filtering flushed ops
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "replayQueue_macros.svh"

module ReplayQueue
    import ReplayQueuePkg::*;
(
    input  logic                      clk,
    input  logic                      reset,
    input  ReplayEntry                record,
    input  MshrState [`MSHR_NUM-1:0]  mshrState,
    input  RecoveryReq                recovery,
    output ReplayEntry                replayOut,
    output logic                      replay,
    output logic                      stallUpper,
    output logic [`MSHR_NUM-1:0]      mshrRelease
);

    logic       push;
    logic       pop;
    logic       full;
    logic       empty;
    RqIndex     headPtr;
    RqIndex     tailPtr;
    RqCount     count;
    ReplayEntry recordData;
    ReplayEntry headEntry;
    ReplayEntry replayEntry;

    ReplayQueuePointer pointer (
        .clk     (clk),
        .reset   (reset),
        .push    (push),
        .pop     (pop),
        .headPtr (headPtr),
        .tailPtr (tailPtr),
        .count   (count),
        .full    (full),
        .empty   (empty)
    );

    ReplayQueueRam ram (
        .clk       (clk),
        .we        (push),
        .writeAddr (tailPtr),
        .readAddr  (headPtr),
        .writeData (recordData),
        .readData  (headEntry)
    );

    ReplayScheduler scheduler (
        .clk         (clk),
        .reset       (reset),
        .record      (record),
        .headEntry   (headEntry),
        .full        (full),
        .empty       (empty),
        .mshrState   (mshrState),
        .push        (push),
        .pop         (pop),
        .recordOut   (recordData),
        .replayEntry (replayEntry),
        .replay      (replay)
    );

    ReplayFlushFilter flushFilter (
        .clk         (clk),
        .reset       (reset),
        .recovery    (recovery),
        .count       (count),
        .replayEntry (replayEntry),
        .replay      (replay),
        .replayOut   (replayOut),
        .mshrRelease (mshrRelease)
    );

    // Leave room for the pushes already in flight when the stall lands
    assign stallUpper = replay ||
                        (count >= RqCount'(`RQ_ENTRY_NUM - `RQ_MEM_LATENCY));

endmodule

// ==== src/ReplayQueuePkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Replay queue types
// Lane and entry layouts, MSHR state and the recovery request
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "replayQueue_macros.svh"

package ReplayQueuePkg;

    typedef logic [`RQ_INDEX_BITS-1:0]    RqIndex;
    typedef logic [`RQ_COUNT_BITS-1:0]    RqCount;
    typedef logic [`RQ_INTERVAL_BITS-1:0] RqInterval;
    typedef logic [`ACTIVE_LIST_BITS-1:0] ActiveListPtr;
    typedef logic [`MSHR_ID_BITS-1:0]     MshrId;
    typedef logic [`OP_TAG_BITS-1:0]      OpTag;

    typedef enum logic {
        MEM_OP_LOAD,
        MEM_OP_STORE
    } MemOpType;

    // Phases from WRITE_CACHE onward mean the fill data is in
    typedef enum logic [1:0] {
        MSHR_PHASE_FREE,
        MSHR_PHASE_MISS_REQUEST,
        MSHR_PHASE_WRITE_CACHE,
        MSHR_PHASE_RELEASE
    } MshrPhase;

    typedef struct packed {
        logic         valid;
        ActiveListPtr activeListPtr;
        OpTag         tag;
    } IntLane;

    typedef struct packed {
        logic         valid;
        ActiveListPtr activeListPtr;
        OpTag         tag;
        MemOpType     opType;
        logic         hasMshr;
        MshrId        mshrId;
    } MemLane;

    typedef struct packed {
        IntLane [`RQ_INT_WIDTH-1:0] intLanes;
        MemLane [`RQ_MEM_WIDTH-1:0] memLanes;
        // Cycles since the previous push
        RqInterval                  interval;
    } ReplayEntry;

    typedef struct packed {
        logic     valid;
        MshrPhase phase;
    } MshrState;

    typedef struct packed {
        logic         strobe;
        ActiveListPtr flushHeadPtr;
        ActiveListPtr flushTailPtr;
    } RecoveryReq;

endpackage

// ==== src/ReplayQueuePointer.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Replay queue pointers
// Circular head and tail with an occupancy count and full/empty flags
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "replayQueue_macros.svh"

module ReplayQueuePointer
    import ReplayQueuePkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  logic   push,
    input  logic   pop,
    output RqIndex headPtr,
    output RqIndex tailPtr,
    output RqCount count,
    output logic   full,
    output logic   empty
);

    function automatic RqIndex nextIndex(RqIndex ptr);
        if (ptr == RqIndex'(`RQ_ENTRY_NUM - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            headPtr <= '0;
            tailPtr <= '0;
            count   <= '0;
        end else begin
            if (push) begin
                tailPtr <= nextIndex(tailPtr);
            end
            if (pop) begin
                headPtr <= nextIndex(headPtr);
            end
            // Simultaneous push and pop leaves the count alone
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign full  = (count == RqCount'(`RQ_ENTRY_NUM));
    assign empty = (count == '0);

endmodule

// ==== src/ReplayQueueRam.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Replay queue storage
// Entry array, written on the clock and read combinationally
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "replayQueue_macros.svh"

module ReplayQueueRam
    import ReplayQueuePkg::*;
(
    input  logic       clk,
    input  logic       we,
    input  RqIndex     writeAddr,
    input  RqIndex     readAddr,
    input  ReplayEntry writeData,
    output ReplayEntry readData
);

    ReplayEntry entries [`RQ_ENTRY_NUM];

    always_ff @(posedge clk) begin
        if (we) begin
            entries[writeAddr] <= writeData;
        end
    end

    assign readData = entries[readAddr];

endmodule

// ==== src/ReplayScheduler.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Replay scheduler
// Records push spacing, holds the head for spacing and MSHR fills,
// and registers each popped entry for replay
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "replayQueue_macros.svh"

module ReplayScheduler
    import ReplayQueuePkg::*;
(
    input  logic                       clk,
    input  logic                       reset,
    input  ReplayEntry                 record,
    input  ReplayEntry                 headEntry,
    input  logic                       full,
    input  logic                       empty,
    input  MshrState [`MSHR_NUM-1:0]   mshrState,
    output logic                       push,
    output logic                       pop,
    output ReplayEntry                 recordOut,
    output ReplayEntry                 replayEntry,
    output logic                       replay
);

    RqInterval  pushInterval;
    RqInterval  popInterval;
    logic       mshrWait;
    ReplayEntry nextReplayEntry;

    function automatic logic anyLaneValid(ReplayEntry e);
        logic v;
        v = 1'b0;
        for (int i = 0; i < `RQ_INT_WIDTH; i++) begin
            v |= e.intLanes[i].valid;
        end
        for (int i = 0; i < `RQ_MEM_WIDTH; i++) begin
            v |= e.memLanes[i].valid;
        end
        return v;
    endfunction

    // Records arriving while full are dropped
    assign push = anyLaneValid(record) && !full;

    always_comb begin
        recordOut          = record;
        recordOut.interval = pushInterval;
    end

    // Head load still waiting on its miss fill
    always_comb begin
        mshrWait = 1'b0;
        for (int i = 0; i < `RQ_MEM_WIDTH; i++) begin
            if (headEntry.memLanes[i].valid &&
                headEntry.memLanes[i].opType == MEM_OP_LOAD &&
                headEntry.memLanes[i].hasMshr &&
                mshrState[headEntry.memLanes[i].mshrId].phase < MSHR_PHASE_WRITE_CACHE) begin
                mshrWait = 1'b1;
            end
        end
    end

    assign pop = !empty && (popInterval >= headEntry.interval) && !mshrWait;

    // Popped entry, valid only in its pop cycle
    always_comb begin
        nextReplayEntry = headEntry;
        for (int i = 0; i < `RQ_INT_WIDTH; i++) begin
            nextReplayEntry.intLanes[i].valid = pop && headEntry.intLanes[i].valid;
        end
        for (int i = 0; i < `RQ_MEM_WIDTH; i++) begin
            nextReplayEntry.memLanes[i].valid = pop && headEntry.memLanes[i].valid;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pushInterval <= '0;
            popInterval  <= '0;
        end else begin
            if (push) begin
                pushInterval <= '0;
            end else if (pushInterval < RqInterval'(`RQ_MAX_INTERVAL)) begin
                pushInterval <= pushInterval + 1'b1;
            end
            if (pop) begin
                popInterval <= '0;
            end else if (popInterval < RqInterval'(`RQ_MAX_INTERVAL)) begin
                popInterval <= popInterval + 1'b1;
            end
        end
    end

    // Replay stage
    always_ff @(posedge clk) begin
        replayEntry <= nextReplayEntry;
        replay      <= pop;
        if (reset) begin
            replay <= 1'b0;
            for (int i = 0; i < `RQ_INT_WIDTH; i++) begin
                replayEntry.intLanes[i].valid <= 1'b0;
            end
            for (int i = 0; i < `RQ_MEM_WIDTH; i++) begin
                replayEntry.memLanes[i].valid <= 1'b0;
            end
        end
    end

endmodule

// ==== src/replayQueue_macros.svh ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Replay queue sizing
// Lane counts, queue depth, interval range, MSHR count and the
// pointer widths shared by the replay queue blocks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef REPLAY_QUEUE_MACROS_SVH
`define REPLAY_QUEUE_MACROS_SVH

// Lanes recorded per entry
`define RQ_INT_WIDTH        2
`define RQ_MEM_WIDTH        1

// Queue storage
`define RQ_ENTRY_NUM        8
`define RQ_INDEX_BITS       3
`define RQ_COUNT_BITS       4

// Interval counters saturate here
`define RQ_MAX_INTERVAL     7
`define RQ_INTERVAL_BITS    3

// Pushes still in flight once the upper stages stall
`define RQ_MEM_LATENCY      3

// Memory side and op identity
`define MSHR_NUM            2
`define MSHR_ID_BITS        1
`define ACTIVE_LIST_BITS    4
`define OP_TAG_BITS         8

`endif

// ==== tb/replayQueueTests.svh ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Replay queue directed tests
// Reset, order and spacing, MSHR wait, almost full and flush
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// Runs right after reset drops, before any clock edge without reset
task automatic testReset();
    if (replay !== 1'b0) reportValue("replay", 32'(replay), 32'h0);
    if (stallUpper !== 1'b0) reportValue("stallUpper", 32'(stallUpper), 32'h0);
    if (mshrRelease !== '0) reportValue("mshrRelease", 32'(mshrRelease), 32'h0);
    if (validBits(replayOut) !== '0) begin
        reportValue("replayOut valid", 32'(validBits(replayOut)), 32'h0);
    end
endtask

task automatic testOrderSpacing();
    int   gaps [4] = '{0, 2, 1, 3};
    OpTag tags [5];
    int   base;
    int   gap;
    int   minGap;
    base = capEntry.size();
    for (int i = 0; i < 5; i++) begin
        tags[i] = OpTag'($random(seed));
        driveRecord(makeEntry(tags[i], ActiveListPtr'($random(seed)), 1'b0, MEM_OP_LOAD,
                              1'b0, 1'b0));
        if (i < 4) idleCycles(gaps[i]);
    end
    driveRecord('0);
    waitReplays(base + 5, 60);
    if (capEntry.size() >= base + 5) begin
        for (int i = 0; i < 5; i++) begin
            if (capEntry[base + i].intLanes[0].tag !== tags[i]) begin
                reportValue("replayOut.intLanes[0].tag", 32'(capEntry[base + i].intLanes[0].tag),
                            32'(tags[i]));
            end
        end
        // Idle cycles between replays never undercut the recorded spacing
        for (int i = 1; i < 5; i++) begin
            gap    = capCycle[base + i] - capCycle[base + i - 1] - 1;
            minGap = (gaps[i - 1] > `RQ_MAX_INTERVAL) ? `RQ_MAX_INTERVAL : gaps[i - 1];
            if (gap < minGap) reportValue("replay gap", 32'(gap), 32'(minGap));
        end
    end
endtask

task automatic testMshrWait();
    OpTag loadTag;
    OpTag nextTag;
    int   base;
    base    = capEntry.size();
    loadTag = OpTag'($random(seed));
    nextTag = OpTag'($random(seed));
    @(negedge clk);
    mshrState[1].valid = 1'b1;
    mshrState[1].phase = MSHR_PHASE_MISS_REQUEST;
    driveRecord(makeEntry(loadTag, 4'd1, 1'b1, MEM_OP_LOAD, 1'b1, 1'b1));
    driveRecord(makeEntry(nextTag, 4'd8, 1'b0, MEM_OP_LOAD, 1'b0, 1'b0));
    driveRecord('0);
    repeat (20) @(posedge clk);
    if (capEntry.size() != base) begin
        otherErrors++;
        $display("Replay fired while the head load was still waiting for its fill");
    end
    @(negedge clk);
    mshrState[1].phase = MSHR_PHASE_WRITE_CACHE;
    waitReplays(base + 2, 20);
    if (capEntry.size() >= base + 2) begin
        if (capEntry[base].intLanes[0].tag !== loadTag) begin
            reportValue("replayOut.intLanes[0].tag", 32'(capEntry[base].intLanes[0].tag),
                        32'(loadTag));
        end
        if (capEntry[base].memLanes[0].valid !== 1'b1) begin
            reportValue("replayOut.memLanes[0].valid", 32'(capEntry[base].memLanes[0].valid),
                        32'h1);
        end
        if (capEntry[base + 1].intLanes[0].tag !== nextTag) begin
            reportValue("replayOut.intLanes[0].tag",
                        32'(capEntry[base + 1].intLanes[0].tag), 32'(nextTag));
        end
    end
endtask

task automatic testAlmostFull();
    OpTag tags [7];
    int   base;
    base = capEntry.size();
    @(negedge clk);
    mshrState[1].phase = MSHR_PHASE_MISS_REQUEST;
    for (int i = 0; i < 7; i++) begin
        tags[i] = OpTag'($random(seed));
        if (i == 0) begin
            driveRecord(makeEntry(tags[i], 4'd0, 1'b1, MEM_OP_LOAD, 1'b1, 1'b1));
        end else begin
            driveRecord(makeEntry(tags[i], ActiveListPtr'($random(seed)), 1'b0,
                                  MEM_OP_LOAD, 1'b0, 1'b0));
        end
        // i entries are queued at this point
        if (stallUpper !== (i >= STALL_LEVEL)) begin
            reportValue("stallUpper", 32'(stallUpper), 32'(i >= STALL_LEVEL));
        end
    end
    driveRecord('0);
    idleCycles(5);
    if (stallUpper !== 1'b1) reportValue("stallUpper", 32'(stallUpper), 32'h1);
    mshrState[1].phase = MSHR_PHASE_WRITE_CACHE;
    waitReplays(base + 7, 30);
    for (int i = 0; i < 7 && base + i < capEntry.size(); i++) begin
        if (capEntry[base + i].intLanes[0].tag !== tags[i]) begin
            reportValue("replayOut.intLanes[0].tag", 32'(capEntry[base + i].intLanes[0].tag),
                        32'(tags[i]));
        end
    end
    idleCycles(2);
    if (stallUpper !== 1'b0) reportValue("stallUpper", 32'(stallUpper), 32'h0);
endtask

task automatic testFlush();
    OpTag                 tags [4];
    logic [LANES-1:0]     expValid [4] = '{3'b011, 3'b000, 3'b111, 3'b111};
    logic [`MSHR_NUM-1:0] expRelease [4] = '{2'b01, 2'b00, 2'b00, 2'b00};
    int                   base;
    base = capEntry.size();
    for (int i = 0; i < 4; i++) begin
        tags[i] = OpTag'($random(seed));
    end
    @(negedge clk);
    mshrState[0].valid = 1'b1;
    mshrState[0].phase = MSHR_PHASE_MISS_REQUEST;
    // Flush range 4..9 catches the load on 4 and both int lanes on 5, 6
    driveRecord(makeEntry(tags[0], 4'd2, 1'b1, MEM_OP_LOAD, 1'b1, 1'b0));
    driveRecord(makeEntry(tags[1], 4'd5, 1'b0, MEM_OP_LOAD, 1'b0, 1'b0));
    driveRecord(makeEntry(tags[2], 4'd10, 1'b1, MEM_OP_STORE, 1'b0, 1'b0));
    driveRecord('0);
    recovery.strobe       = 1'b1;
    recovery.flushHeadPtr = 4'd4;
    recovery.flushTailPtr = 4'd9;
    @(negedge clk);
    recovery = '0;
    mshrState[0].phase = MSHR_PHASE_WRITE_CACHE;
    waitReplays(base + 3, 30);
    // Pointers inside the old range, but the captured count has run out
    driveRecord(makeEntry(tags[3], 4'd5, 1'b1, MEM_OP_LOAD, 1'b0, 1'b0));
    driveRecord('0);
    waitReplays(base + 4, 20);
    for (int i = 0; i < 4 && base + i < capEntry.size(); i++) begin
        if (validBits(capEntry[base + i]) !== expValid[i]) begin
            reportValue("replayOut valid", 32'(validBits(capEntry[base + i])), 32'(expValid[i]));
        end
        if (capRelease[base + i] !== expRelease[i]) begin
            reportValue("mshrRelease", 32'(capRelease[base + i]), 32'(expRelease[i]));
        end
        if (capEntry[base + i].intLanes[0].tag !== tags[i]) begin
            reportValue("replayOut.intLanes[0].tag", 32'(capEntry[base + i].intLanes[0].tag),
                        32'(tags[i]));
        end
    end
endtask

// ==== tb/ReplayQueueTb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Replay queue testbench
// Clock, reset, DUT, replay capture monitor, watchdog and the
// closing report around the directed tests
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "replayQueue_macros.svh"

module ReplayQueueTb
    import ReplayQueuePkg::*;
();

    localparam int CLK_PERIOD  = 8;
    // Rough length of the whole directed run in clock cycles
    localparam int TEST_CYCLES = 200;
    localparam int STALL_LEVEL = `RQ_ENTRY_NUM - `RQ_MEM_LATENCY;
    localparam int LANES       = `RQ_INT_WIDTH + `RQ_MEM_WIDTH;

    logic                     clk;
    logic                     reset;
    ReplayEntry               record;
    MshrState [`MSHR_NUM-1:0] mshrState;
    RecoveryReq               recovery;
    ReplayEntry               replayOut;
    logic                     replay;
    logic                     stallUpper;
    logic [`MSHR_NUM-1:0]     mshrRelease;

    int seed;
    int cycle = 0;
    int valueErrors;
    int otherErrors;

    // Everything seen on the replay port per replay cycle
    ReplayEntry           capEntry [$];
    int                   capCycle [$];
    logic [`MSHR_NUM-1:0] capRelease [$];

    ReplayQueue dut (
        .clk         (clk),
        .reset       (reset),
        .record      (record),
        .mshrState   (mshrState),
        .recovery    (recovery),
        .replayOut   (replayOut),
        .replay      (replay),
        .stallUpper  (stallUpper),
        .mshrRelease (mshrRelease)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // Log each replay cycle with its payload
    always @(negedge clk) begin
        if (!reset && replay) begin
            capEntry.push_back(replayOut);
            capCycle.push_back(cycle);
            capRelease.push_back(mshrRelease);
            $display("[%0t] replay in cycle %0d, tags %h %h %h, valid %b", $time, cycle,
                     replayOut.intLanes[0].tag, replayOut.intLanes[1].tag,
                     replayOut.memLanes[0].tag, validBits(replayOut));
        end
    end

    initial begin
        #(TEST_CYCLES * 2 * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, the run did not finish", cycle);
        $display("TESTS FAILED");
        $finish;
    end

    function automatic logic [LANES-1:0] validBits(input ReplayEntry e);
        logic [LANES-1:0] v;
        for (int i = 0; i < `RQ_INT_WIDTH; i++) begin
            v[i] = e.intLanes[i].valid;
        end
        for (int i = 0; i < `RQ_MEM_WIDTH; i++) begin
            v[`RQ_INT_WIDTH + i] = e.memLanes[i].valid;
        end
        return v;
    endfunction

    // Int lanes take ptr, ptr+1; the memory lane takes the next pointer
    function automatic ReplayEntry makeEntry(input OpTag tag, input ActiveListPtr ptr,
                                             input logic memValid, input MemOpType opType,
                                             input logic hasMshr, input MshrId id);
        ReplayEntry e;
        e = '0;
        for (int i = 0; i < `RQ_INT_WIDTH; i++) begin
            e.intLanes[i].valid         = 1'b1;
            e.intLanes[i].activeListPtr = ptr + ActiveListPtr'(i);
            e.intLanes[i].tag           = tag + OpTag'(i);
        end
        e.memLanes[0].valid         = memValid;
        e.memLanes[0].activeListPtr = ptr + ActiveListPtr'(`RQ_INT_WIDTH);
        e.memLanes[0].tag           = tag + OpTag'(`RQ_INT_WIDTH);
        e.memLanes[0].opType        = opType;
        e.memLanes[0].hasMshr       = hasMshr;
        e.memLanes[0].mshrId        = id;
        return e;
    endfunction

    task automatic reportValue(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        valueErrors++;
        $display("[FAIL] %s: got %h, expected %h", name, got, expected);
    endtask

    task automatic driveRecord(input ReplayEntry e);
        @(negedge clk);
        record = e;
    endtask

    task automatic idleCycles(input int n);
        repeat (n) driveRecord('0);
    endtask

    // Drain time between tests lets both interval counters saturate
    task automatic settle();
        idleCycles(10);
        @(posedge clk);
    endtask

    task automatic waitReplays(input int target, input int maxCycles);
        int waited;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
        end while (capEntry.size() < target && waited < maxCycles);
        if (capEntry.size() < target) begin
            otherErrors++;
            $display("Replays did not arrive within %0d cycles, saw %0d of %0d",
                     maxCycles, capEntry.size(), target);
        end
    endtask

    `include "replayQueueTests.svh"

    initial begin
        seed        = 62;
        valueErrors = 0;
        otherErrors = 0;
        reset       = 1'b1;
        record      = '0;
        mshrState   = '0;
        recovery    = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        testReset();
        settle();
        testOrderSpacing();
        settle();
        testMshrWait();
        settle();
        testAlmostFull();
        settle();
        testFlush();
        settle();
        $display("Closing report: %0d value errors, %0d other errors, %0d replays seen",
                 valueErrors, otherErrors, capEntry.size());
        if (valueErrors + otherErrors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule
